/* Makefile */
TOP := rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* design/rv_core.sv */
`include "rv_core_cfg.svh"

module rv_core (
    input  logic                 clk,
    input  logic                 reset_i,
    output logic                 imem_req_o,
    output logic [`RV_XLEN-1:0]  imem_addr_o,
    input  logic                 imem_ack_i,
    input  logic [31:0]          imem_rdata_i,
    output rv_core_pkg::commit_t commit_o,
    output logic                 commit_valid_o,
    output logic                 halted_o
);
    import rv_core_pkg::*;

    fetch_t                fetch;
    logic                  fetch_valid;
    decode_t               dec;
    logic                  dec_valid;
    exec_t                 exe;
    logic                  exe_valid;
    mem_t                  mem;
    logic                  mem_valid;
    redirect_t             redirect;
    logic                  pc_wen;

    // Register file ports
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    logic                  rf_we;
    logic [`RV_REG_AW-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]   rf_wdata;

    rv_register_file u_regfile (
        .clk      (clk),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    rv_fetch_unit u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect),
        .pc_wen_i      (pc_wen),
        .halt_i        (halted_o),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_ack_i    (imem_ack_i),
        .imem_rdata_i  (imem_rdata_i),
        .fetch_o       (fetch),
        .fetch_valid_o (fetch_valid)
    );

    rv_decode_unit u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_i       (fetch),
        .fetch_valid_i (fetch_valid),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rdata1),
        .rs2_data_i    (rdata2),
        .dec_o         (dec),
        .dec_valid_o   (dec_valid),
        .redirect_o    (redirect)
    );

    rv_execute_unit u_execute (
        .clk         (clk),
        .reset_i     (reset_i),
        .dec_i       (dec),
        .dec_valid_i (dec_valid),
        .exe_o       (exe),
        .exe_valid_o (exe_valid)
    );

    rv_memory_unit u_memory (
        .clk         (clk),
        .reset_i     (reset_i),
        .exe_i       (exe),
        .exe_valid_i (exe_valid),
        .mem_o       (mem),
        .mem_valid_o (mem_valid)
    );

    // Writeback releases the next fetch
    rv_writeback_unit u_writeback (
        .clk            (clk),
        .reset_i        (reset_i),
        .mem_i          (mem),
        .mem_valid_i    (mem_valid),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .pc_wen_o       (pc_wen),
        .halt_o         (halted_o),
        .commit_o       (commit_o),
        .commit_valid_o (commit_valid_o)
    );

endmodule

/* design/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Register file address width
`define RV_REG_AW 5

// Data RAM depth in words
`define RV_DMEM_WORDS 64

`endif

/* design/rv_core_pkg.sv */
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT_ACK_LOW,
        FETCH_HOLD
    } fetch_state_e;

    // Register write source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } fetch_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [31:0]           inst;
        logic [`RV_XLEN-1:0]   op1;
        logic [`RV_XLEN-1:0]   op2;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_REG_AW-1:0] rd;
        alu_op_e               alu_op;
        wb_sel_e               wb_sel;
        logic                  mem_wen;
        logic                  mem_ren;
        logic                  reg_we;
        logic                  halt;
    } decode_t;

    typedef struct packed {
        decode_t             dec;
        logic [`RV_XLEN-1:0] result;
    } exec_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [31:0]           inst;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_XLEN-1:0]   load_data;
        wb_sel_e               wb_sel;
        logic                  reg_we;
        logic                  halt;
    } mem_t;

    // Next pc choice made in decode
    typedef struct packed {
        logic                taken;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

    // One record per retired instruction
    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [31:0]           inst;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   wdata;
        logic                  we;
    } commit_t;

endpackage

/* design/rv_decode_unit.sv */
`include "rv_core_cfg.svh"

module rv_decode_unit (
    input  logic                   clk,
    input  logic                   reset_i,
    input  rv_core_pkg::fetch_t    fetch_i,
    input  logic                   fetch_valid_i,
    output logic [`RV_REG_AW-1:0]  rs1_addr_o,
    output logic [`RV_REG_AW-1:0]  rs2_addr_o,
    input  logic [`RV_XLEN-1:0]    rs1_data_i,
    input  logic [`RV_XLEN-1:0]    rs2_data_i,
    output rv_core_pkg::decode_t   dec_o,
    output logic                   dec_valid_o,
    output rv_core_pkg::redirect_t redirect_o
);
    import rv_core_pkg::*;

    logic [31:0]         inst;
    opcode_e             opcode;
    logic [2:0]          funct3;
    logic                rs_equal;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    decode_t             dec_next;
    redirect_t           redir_next;

    assign inst       = fetch_i.inst;
    assign opcode     = opcode_e'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];
    assign rs_equal   = (rs1_data_i == rs2_data_i);

    // Sign-extended immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec_next          = '0;
        dec_next.pc       = fetch_i.pc;
        dec_next.inst     = inst;
        dec_next.op1      = rs1_data_i;
        dec_next.op2      = rs2_data_i;
        dec_next.rs2_data = rs2_data_i;
        dec_next.rd       = inst[11:7];
        dec_next.alu_op   = ALU_ADD;
        dec_next.wb_sel   = WB_ALU;
        redir_next.taken  = 1'b0;
        redir_next.target = fetch_i.pc + imm_b;
        case (opcode)
            OPC_OP: begin
                dec_next.reg_we = 1'b1;
                case (funct3)
                    3'b000: dec_next.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b010: dec_next.alu_op = ALU_SLT;
                    3'b100: dec_next.alu_op = ALU_XOR;
                    3'b110: dec_next.alu_op = ALU_OR;
                    3'b111: dec_next.alu_op = ALU_AND;
                    default: dec_next.reg_we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                dec_next.op2    = imm_i;
                dec_next.reg_we = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                dec_next.op2    = imm_u;
                dec_next.alu_op = ALU_PASS_B;
                dec_next.reg_we = 1'b1;
            end
            OPC_LOAD: begin
                dec_next.op2     = imm_i;
                dec_next.mem_ren = 1'b1;
                dec_next.wb_sel  = WB_MEM;
                dec_next.reg_we  = 1'b1;
            end
            OPC_STORE: begin
                dec_next.op2     = imm_s;
                dec_next.mem_wen = 1'b1;
            end
            OPC_BRANCH: begin
                // BEQ and BNE resolved here
                case (funct3)
                    3'b000: redir_next.taken = rs_equal;
                    3'b001: redir_next.taken = !rs_equal;
                    default: redir_next.taken = 1'b0;
                endcase
            end
            OPC_JAL: begin
                dec_next.wb_sel   = WB_PC4;
                dec_next.reg_we   = 1'b1;
                redir_next.taken  = 1'b1;
                redir_next.target = fetch_i.pc + imm_j;
            end
            OPC_SYSTEM: begin
                dec_next.halt = (inst[31:20] == 12'h001);
            end
            default: begin
                // Unknown opcode retires as a no-op
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
            redirect_o  <= '0;
        end else begin
            dec_valid_o <= fetch_valid_i;
            // Held until fetch consumes it on pc_wen
            if (fetch_valid_i) begin
                redirect_o <= redir_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            dec_o <= dec_next;
        end
    end

endmodule

/* design/rv_execute_unit.sv */
`include "rv_core_cfg.svh"

module rv_execute_unit (
    input  logic                 clk,
    input  logic                 reset_i,
    input  rv_core_pkg::decode_t dec_i,
    input  logic                 dec_valid_i,
    output rv_core_pkg::exec_t   exe_o,
    output logic                 exe_valid_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] alu_result;
    logic                less_than;

    assign less_than = $signed(dec_i.op1) < $signed(dec_i.op2);

    // Loads and stores get their address here
    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_result = dec_i.op1 + dec_i.op2;
            ALU_SUB:    alu_result = dec_i.op1 - dec_i.op2;
            ALU_AND:    alu_result = dec_i.op1 & dec_i.op2;
            ALU_OR:     alu_result = dec_i.op1 | dec_i.op2;
            ALU_XOR:    alu_result = dec_i.op1 ^ dec_i.op2;
            ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, less_than};
            ALU_PASS_B: alu_result = dec_i.op2;
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            exe_o.dec    <= dec_i;
            exe_o.result <= alu_result;
        end
    end

endmodule

/* design/rv_fetch_unit.sv */
`include "rv_core_cfg.svh"

module rv_fetch_unit (
    input  logic                   clk,
    input  logic                   reset_i,
    input  rv_core_pkg::redirect_t redirect_i,
    input  logic                   pc_wen_i,
    input  logic                   halt_i,
    output logic                   imem_req_o,
    output logic [`RV_XLEN-1:0]    imem_addr_o,
    input  logic                   imem_ack_i,
    input  logic [31:0]            imem_rdata_i,
    output rv_core_pkg::fetch_t    fetch_o,
    output logic                   fetch_valid_o
);
    import rv_core_pkg::*;

    fetch_state_e        state;
    logic [`RV_XLEN-1:0] pc;

    assign imem_req_o  = (state == FETCH_REQ);
    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= FETCH_IDLE;
            pc            <= '0;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    state <= FETCH_REQ;
                end
                FETCH_REQ: begin
                    if (imem_ack_i) begin
                        state <= FETCH_WAIT_ACK_LOW;
                    end
                end
                FETCH_WAIT_ACK_LOW: begin
                    // Transfer ends once the responder drops ack
                    if (!imem_ack_i) begin
                        fetch_valid_o <= 1'b1;
                        state         <= FETCH_HOLD;
                    end
                end
                FETCH_HOLD: begin
                    if (pc_wen_i) begin
                        pc <= redirect_i.taken ? redirect_i.target : pc + 4;
                        // A halted core never asks again
                        if (!halt_i) begin
                            state <= FETCH_REQ;
                        end
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // Instruction captured while ack is high
    always_ff @(posedge clk) begin
        if (state == FETCH_REQ && imem_ack_i) begin
            fetch_o.pc   <= pc;
            fetch_o.inst <= imem_rdata_i;
        end
    end

endmodule

/* design/rv_memory_unit.sv */
`include "rv_core_cfg.svh"

module rv_memory_unit (
    input  logic               clk,
    input  logic               reset_i,
    input  rv_core_pkg::exec_t exe_i,
    input  logic               exe_valid_i,
    output rv_core_pkg::mem_t  mem_o,
    output logic               mem_valid_o
);

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] ram [`RV_DMEM_WORDS];
    logic [IDX_W-1:0]    idx;

    // Word index, upper address bits ignored
    assign idx = exe_i.result[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_valid_o <= 1'b0;
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else begin
            mem_valid_o <= exe_valid_i;
            if (exe_valid_i && exe_i.dec.mem_wen) begin
                ram[idx] <= exe_i.dec.rs2_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            mem_o.pc        <= exe_i.dec.pc;
            mem_o.inst      <= exe_i.dec.inst;
            mem_o.rd        <= exe_i.dec.rd;
            mem_o.result    <= exe_i.result;
            mem_o.load_data <= exe_i.dec.mem_ren ? ram[idx] : '0;
            mem_o.wb_sel    <= exe_i.dec.wb_sel;
            mem_o.reg_we    <= exe_i.dec.reg_we;
            mem_o.halt      <= exe_i.dec.halt;
        end
    end

endmodule

/* design/rv_register_file.sv */
`include "rv_core_cfg.svh"

module rv_register_file (
    input  logic                  clk,
    input  logic                  we_i,
    input  logic [`RV_REG_AW-1:0] waddr_i,
    input  logic [`RV_XLEN-1:0]   wdata_i,
    input  logic [`RV_REG_AW-1:0] raddr1_i,
    input  logic [`RV_REG_AW-1:0] raddr2_i,
    output logic [`RV_XLEN-1:0]   rdata1_o,
    output logic [`RV_XLEN-1:0]   rdata2_o
);

    logic [`RV_XLEN-1:0] regs [1 << `RV_REG_AW];

    // x0 never stored
    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads, x0 reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* design/rv_writeback_unit.sv */
`include "rv_core_cfg.svh"

module rv_writeback_unit (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rv_core_pkg::mem_t     mem_i,
    input  logic                  mem_valid_i,
    output logic                  rf_we_o,
    output logic [`RV_REG_AW-1:0] rf_waddr_o,
    output logic [`RV_XLEN-1:0]   rf_wdata_o,
    output logic                  pc_wen_o,
    output logic                  halt_o,
    output rv_core_pkg::commit_t  commit_o,
    output logic                  commit_valid_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] wdata;

    always_comb begin
        case (mem_i.wb_sel)
            WB_MEM:  wdata = mem_i.load_data;
            WB_PC4:  wdata = mem_i.pc + 4;
            default: wdata = mem_i.result;
        endcase
    end

    assign rf_we_o    = mem_valid_i && mem_i.reg_we;
    assign rf_waddr_o = mem_i.rd;
    assign rf_wdata_o = wdata;

    // pc_wen goes out with the commit pulse
    always_ff @(posedge clk) begin
        if (reset_i) begin
            commit_valid_o <= 1'b0;
            pc_wen_o       <= 1'b0;
            halt_o         <= 1'b0;
        end else begin
            commit_valid_o <= mem_valid_i;
            pc_wen_o       <= mem_valid_i;
            if (mem_valid_i && mem_i.halt) begin
                halt_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid_i) begin
            commit_o.pc    <= mem_i.pc;
            commit_o.inst  <= mem_i.inst;
            commit_o.rd    <= mem_i.rd;
            commit_o.wdata <= wdata;
            commit_o.we    <= mem_i.reg_we && (mem_i.rd != '0);
        end
    end

endmodule

/* verification/rv_core_checker.sv */
module rv_core_checker #(
    parameter int NUM_COMMITS = 1
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  rv_core_pkg::commit_t commit_i,
    input  logic                 commit_valid_i,
    input  logic                 halted_i,
    input  rv_core_pkg::commit_t expected_i,
    input  logic                 final_check_i,
    output int                   checked_o,
    output int                   pass_count_o,
    output int                   fail_count_o
);

    int mismatches;

    function automatic int field_diff(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        if (reset_i) begin
            checked_o    = 0;
            pass_count_o = 0;
            fail_count_o = 0;
        end else begin
            if (commit_valid_i && checked_o >= NUM_COMMITS) begin
                $display("Unexpected commit at pc %h after the last expected commit",
                         commit_i.pc);
                fail_count_o = fail_count_o + 1;
            end else if (commit_valid_i) begin
                mismatches = field_diff("commit_o.pc", expected_i.pc, commit_i.pc);
                mismatches += field_diff("commit_o.inst", expected_i.inst, commit_i.inst);
                mismatches += field_diff("commit_o.we", 32'(expected_i.we), 32'(commit_i.we));
                // rd and wdata only matter when a register is written
                if (expected_i.we) begin
                    mismatches += field_diff("commit_o.rd", 32'(expected_i.rd), 32'(commit_i.rd));
                    mismatches += field_diff("commit_o.wdata", expected_i.wdata, commit_i.wdata);
                end
                if (mismatches == 0) begin
                    pass_count_o = pass_count_o + 1;
                    $display("Commit %0d at pc %h ok", checked_o, commit_i.pc);
                end else begin
                    fail_count_o = fail_count_o + 1;
                    $display("Commit %0d at pc %h failed", checked_o, commit_i.pc);
                end
                checked_o = checked_o + 1;
            end
            // Core must be halted once the table is done
            if (final_check_i) begin
                if (field_diff("halted_o", 32'h1, 32'(halted_i)) == 0) begin
                    pass_count_o = pass_count_o + 1;
                    $display("Halt check ok");
                end else begin
                    fail_count_o = fail_count_o + 1;
                    $display("Halt check failed");
                end
            end
        end
    end

endmodule

/* verification/rv_core_props.sv */
`include "rv_core_cfg.svh"

module rv_core_props (
    input logic                clk,
    input logic                reset_i,
    input logic                req_i,
    input logic [`RV_XLEN-1:0] addr_i,
    input logic                ack_i,
    input logic                commit_valid_i,
    input logic                halted_i
);

    int violations = 0;

    // Request held until the responder acknowledges
    req_until_ack: assert property (
        @(posedge clk) disable iff (reset_i) req_i && !ack_i |=> req_i
    ) else begin
        violations++;
        $error("imem_req_o dropped before imem_ack_i");
    end

    addr_stable: assert property (
        @(posedge clk) disable iff (reset_i) req_i |=> !req_i || $stable(addr_i)
    ) else begin
        violations++;
        $error("imem_addr_o changed during a request");
    end

    // One record per retired instruction
    commit_one_cycle: assert property (
        @(posedge clk) disable iff (reset_i) commit_valid_i |=> !commit_valid_i
    ) else begin
        violations++;
        $error("commit_valid_o high for more than one cycle");
    end

    no_req_after_halt: assert property (
        @(posedge clk) disable iff (reset_i) halted_i |-> !req_i
    ) else begin
        violations++;
        $error("imem_req_o raised after halted_o");
    end

endmodule

/* verification/rv_core_tb.sv */
`include "rv_core_cfg.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int NUM_COMMITS    = 23;
    localparam int MAX_ACK_DELAY  = 3;
    localparam int RESET_CYCLES   = 2;
    localparam int DRAIN_CYCLES   = 30;
    // One instruction needs well under 12 cycles even with the slowest ack
    localparam int TIMEOUT_CYCLES = NUM_COMMITS * 12 + MAX_ACK_DELAY + RESET_CYCLES
                                    + DRAIN_CYCLES + 2;

    logic                clk;
    logic                reset_i;
    logic                imem_req_o;
    logic [`RV_XLEN-1:0] imem_addr_o;
    logic                imem_ack_i;
    logic [31:0]         imem_rdata_i;
    commit_t             commit_o;
    logic                commit_valid_o;
    logic                halted_o;

    commit_t             expected;
    logic                final_check;
    int                  checked;
    int                  pass_count;
    int                  fail_count;

    // Program by word address, expected commits in retire order
    logic [31:0]         prog [64];
    commit_t             expect_table [NUM_COMMITS];
    int                  num_expect;
    integer              seed;
    int                  ack_delay;

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic place_inst(input int pc, input logic [31:0] inst);
        prog[pc[7:2]] = inst;
    endtask

    task automatic add_commit(input int pc, input logic [31:0] inst, input int rd,
                              input logic [31:0] wdata, input logic we);
        place_inst(pc, inst);
        expect_table[num_expect].pc    = pc;
        expect_table[num_expect].inst  = inst;
        expect_table[num_expect].rd    = rd[4:0];
        expect_table[num_expect].wdata = wdata;
        expect_table[num_expect].we    = we;
        num_expect++;
    endtask

    task automatic build_tables();
        // Unused words hold addi x0, x0, index
        for (int a = 0; a < 64; a++) begin
            prog[a] = i_type(a, 0, 0, 0, OPC_OP_IMM);
        end
        add_commit(32'h00, i_type(5, 0, 0, 1, OPC_OP_IMM), 1, 32'h00000005, 1'b1);
        add_commit(32'h04, i_type(-3, 0, 0, 2, OPC_OP_IMM), 2, 32'hfffffffd, 1'b1);
        add_commit(32'h08, r_type(0, 2, 1, 0, 3), 3, 32'h00000002, 1'b1);
        add_commit(32'h0c, r_type('h20, 1, 2, 0, 4), 4, 32'hfffffff8, 1'b1);
        add_commit(32'h10, r_type(0, 2, 1, 7, 5), 5, 32'h00000005, 1'b1);
        add_commit(32'h14, r_type(0, 2, 1, 6, 6), 6, 32'hfffffffd, 1'b1);
        add_commit(32'h18, r_type(0, 2, 1, 4, 7), 7, 32'hfffffff8, 1'b1);
        add_commit(32'h1c, r_type(0, 1, 2, 2, 8), 8, 32'h00000001, 1'b1);
        add_commit(32'h20, r_type(0, 2, 1, 2, 9), 9, 32'h00000000, 1'b1);
        add_commit(32'h24, u_type('h80000, 10), 10, 32'h80000000, 1'b1);
        // Signed overflow wraps
        add_commit(32'h28, r_type('h20, 1, 10, 0, 11), 11, 32'h7ffffffb, 1'b1);
        // Write to x0 then read it back
        add_commit(32'h2c, i_type(7, 1, 0, 0, OPC_OP_IMM), 0, 32'h0, 1'b0);
        add_commit(32'h30, r_type(0, 1, 0, 0, 12), 12, 32'h00000005, 1'b1);
        add_commit(32'h34, s_type(8, 4, 0), 0, 32'h0, 1'b0);
        add_commit(32'h38, i_type(8, 0, 2, 13, OPC_LOAD), 13, 32'hfffffff8, 1'b1);
        add_commit(32'h3c, i_type(40, 0, 2, 14, OPC_LOAD), 14, 32'h00000000, 1'b1);
        // Taken, not taken, taken, not taken
        add_commit(32'h40, b_type(8, 12, 1, 0), 0, 32'h0, 1'b0);
        place_inst(32'h44, i_type(1, 0, 0, 15, OPC_OP_IMM));
        add_commit(32'h48, b_type(8, 12, 1, 1), 0, 32'h0, 1'b0);
        add_commit(32'h4c, b_type(12, 3, 1, 1), 0, 32'h0, 1'b0);
        place_inst(32'h50, i_type(2, 0, 0, 15, OPC_OP_IMM));
        place_inst(32'h54, i_type(3, 0, 0, 15, OPC_OP_IMM));
        add_commit(32'h58, b_type(8, 3, 1, 0), 0, 32'h0, 1'b0);
        add_commit(32'h5c, j_type(16, 16), 16, 32'h00000060, 1'b1);
        place_inst(32'h60, i_type(4, 0, 0, 15, OPC_OP_IMM));
        place_inst(32'h64, i_type(5, 0, 0, 15, OPC_OP_IMM));
        place_inst(32'h68, i_type(6, 0, 0, 15, OPC_OP_IMM));
        add_commit(32'h6c, i_type(1, 16, 0, 17, OPC_OP_IMM), 17, 32'h00000061, 1'b1);
        add_commit(32'h70, 32'h00100073, 0, 32'h0, 1'b0);
    endtask

    rv_core rv_core_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .imem_ack_i     (imem_ack_i),
        .imem_rdata_i   (imem_rdata_i),
        .commit_o       (commit_o),
        .commit_valid_o (commit_valid_o),
        .halted_o       (halted_o)
    );

    rv_core_checker #(
        .NUM_COMMITS (NUM_COMMITS)
    ) checker_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .commit_i       (commit_o),
        .commit_valid_i (commit_valid_o),
        .halted_i       (halted_o),
        .expected_i     (expected),
        .final_check_i  (final_check),
        .checked_o      (checked),
        .pass_count_o   (pass_count),
        .fail_count_o   (fail_count)
    );

    bind rv_core rv_core_props props_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_i          (imem_req_o),
        .addr_i         (imem_addr_o),
        .ack_i          (imem_ack_i),
        .commit_valid_i (commit_valid_o),
        .halted_i       (halted_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Instruction port responder with a random ack delay
    initial begin
        imem_ack_i   = 1'b0;
        imem_rdata_i = '0;
        seed         = 43;
        forever begin
            @(negedge clk);
            if (imem_req_o && !reset_i) begin
                ack_delay = {$random(seed)} % (MAX_ACK_DELAY + 1);
                repeat (ack_delay) @(negedge clk);
                imem_rdata_i = prog[imem_addr_o[7:2]];
                imem_ack_i   = 1'b1;
                @(negedge clk);
                while (imem_req_o) begin
                    @(negedge clk);
                end
                imem_ack_i = 1'b0;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d commits checked",
                 TIMEOUT_CYCLES, checked, NUM_COMMITS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset_i     = 1'b1;
        final_check = 1'b0;
        expected    = '0;
        num_expect  = 0;
        build_tables();
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        for (int i = 0; i < NUM_COMMITS; i++) begin
            expected = expect_table[i];
            while (checked <= i) begin
                @(negedge clk);
            end
        end
        // Any commit after EBREAK shows up during the drain
        repeat (DRAIN_CYCLES) @(negedge clk);
        final_check = 1'b1;
        @(negedge clk);
        final_check = 1'b0;
        $display("Checks passed %0d, failed %0d, assertion failures %0d",
                 pass_count, fail_count, rv_core_inst.props_inst.violations);
        if (fail_count == 0 && rv_core_inst.props_inst.violations == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/rv_core_pkg.sv
design/rv_fetch_unit.sv
design/rv_decode_unit.sv
design/rv_register_file.sv
design/rv_execute_unit.sv
design/rv_memory_unit.sv
design/rv_writeback_unit.sv
design/rv_core.sv
verification/rv_core_props.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv
